/* verilog/board_pkg.sv */
// board register file shared definitions
// page-0 register map, version words, axis count and watchdog constants
package board_pkg;

    //--------------------
    // page-0 register map
    //--------------------
    typedef enum logic [3:0] {
        reg_status     = 4'd0,   // enables, faults, relay, power, board id
        reg_phyctrl    = 4'd1,   // phy request word
        reg_phydata    = 4'd2,   // phy register contents
        reg_timeout    = 4'd3,   // watchdog period
        reg_version    = 4'd4,   // hard-wired board version
        reg_tempsns    = 4'd5,   // temperature sensors
        reg_digiout    = 4'd6,   // digital outputs
        reg_fw_version = 4'd7,   // firmware version
        reg_promstat   = 4'd8,   // prom interface status
        reg_promres    = 4'd9,   // prom result word
        reg_digin      = 4'd10,  // home, limits, dout, v_fault
        reg_safety     = 4'd11,  // safety amp disable
        reg_cur1       = 4'd12,  // debug slot, reads zero
        reg_dac1       = 4'd13,  // debug slot, reads zero
        reg_wdog       = 4'd14,  // watchdog flag per axis
        reg_ampdis     = 4'd15   // effective amp disable
    } board_reg_e;

    //--------------------
    // board constants
    //--------------------

    // fixed by the amplifier board
    localparam int num_axes = 4;

    // "QLA1" in ascii
    localparam logic [31:0] board_version = 32'h514C_4131;

    localparam logic [31:0] fw_version = 32'h0000_0001;

    //--------------------
    // watchdog
    //--------------------

    // one tick per 2**8 sysclk cycles
    localparam int wdog_div_width = 8;

    // max period out of reset, host shortens or zeroes it
    localparam logic [15:0] wdog_period_reset = 16'hFFFF;

endpackage

/* verilog/board_ifs.sv */
// board register file internal buses
// reg_access_if carries one decoded host access
// ctrl_state_if carries the control state out of the write stage

interface reg_access_if;
    logic                    wr;     // one-cycle write pulse, page 0 only
    logic                    rd;     // page-0 read selected
    board_pkg::board_reg_e   sel;    // register within page 0
    logic [31:0]             wdata;  // registered write data

    modport decode (output wr, output rd, output sel, output wdata);
    modport exec   (input wr, input sel, input wdata);
    modport result (input wr, input rd, input sel);
    modport kick   (input wr);       // watchdog only cares about writes
endinterface

interface ctrl_state_if;
    logic [board_pkg::num_axes-1:0] reg_disable;  // host disable bits
    logic [board_pkg::num_axes-1:0] amp_disable;  // host or safety
    logic                           relay_on;     // safety relay drive
    logic                           pwr_enable;   // motor power
    logic [3:0]                     dout;         // digital outputs
    logic [15:0]                    phy_ctrl;
    logic [15:0]                    phy_data;
    logic [15:0]                    wdog_period;  // in watchdog ticks

    modport owner (
        output reg_disable, output amp_disable, output relay_on,
        output pwr_enable, output dout, output phy_ctrl,
        output phy_data, output wdog_period
    );

    modport view (
        input reg_disable, input amp_disable, input relay_on,
        input pwr_enable, input dout, input phy_ctrl,
        input phy_data, input wdog_period
    );
endinterface

/* verilog/reg_decode.sv */
// host access decode
// first pipeline stage, registers address, data and strobe
// then qualifies by page 0 and selects the board register
module reg_decode (
    input  logic        sysclk,
    input  logic        reset,      // sync, active low
    input  logic [7:0]  reg_addr,
    input  logic [31:0] reg_wdata,
    input  logic        wr_en,
    reg_access_if.decode acc
);

    logic [7:0]  addr_q;   // level address, sampled each cycle
    logic [31:0] wdata_q;  // registered write payload
    logic        wr_q;     // raw strobe before page check
    logic        page0;

    //--------------------
    // input register
    //--------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            addr_q <= 8'd0;
            wr_q   <= 1'b0;
        end else begin
            addr_q <= reg_addr;
            wr_q   <= wr_en;
        end
    end

    always_ff @(posedge sysclk) begin
        wdata_q <= reg_wdata;
    end

    //--------------------
    // page and register select
    //--------------------

    // board registers live in page 0 only
    assign page0 = (addr_q[7:4] == 4'd0);

    assign acc.wr    = wr_q & page0;    // other pages dropped here
    assign acc.rd    = ~wr_q & page0;   // reads need no strobe
    assign acc.sel   = board_pkg::board_reg_e'(addr_q[3:0]);
    assign acc.wdata = wdata_q;

endmodule

/* verilog/board_ctrl_regs.sv */
// board control registers
// applies decoded writes to axis disables, relay, power, digital outputs,
// phy words and watchdog period; timeout forces every axis disabled
module board_ctrl_regs (
    input  logic                           sysclk,
    input  logic                           reset,   // sync, active low
    reg_access_if.exec                     acc,
    input  logic                           timeout, // from watchdog
    input  logic [board_pkg::num_axes-1:0] safety_amp_disable,
    ctrl_state_if.owner                    st
);

    logic [board_pkg::num_axes-1:0] reg_disable;  // 1 -> axis off
    logic                           relay_on;
    logic                           pwr_enable;
    logic [3:0]                     dout;
    logic [15:0]                    phy_ctrl;
    logic [15:0]                    phy_data;
    logic [15:0]                    wdog_period;

    //--------------------
    // write execution
    //--------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_disable <= '1;                        // every axis starts off
            relay_on    <= 1'b0;
            pwr_enable  <= 1'b0;                      // power off at start
            dout        <= 4'd0;
            phy_ctrl    <= 16'd0;
            phy_data    <= 16'd0;
            wdog_period <= board_pkg::wdog_period_reset;
        end else begin
            if (acc.wr) begin
                case (acc.sel)
                    board_pkg::reg_status: begin
                        // mask 11:8 lets enable 3:0 through, stored inverted
                        for (int i = 0; i < board_pkg::num_axes; i++) begin
                            if (acc.wdata[8 + i]) begin
                                reg_disable[i] <= ~acc.wdata[i];
                            end
                        end
                        if (acc.wdata[17]) begin
                            relay_on <= acc.wdata[16];    // relay pair
                        end
                        if (acc.wdata[19]) begin
                            pwr_enable <= acc.wdata[18];  // power pair
                        end
                    end
                    board_pkg::reg_digiout: begin
                        // same mask layout as the enables, not inverted
                        for (int i = 0; i < 4; i++) begin
                            if (acc.wdata[8 + i]) begin
                                dout[i] <= acc.wdata[i];
                            end
                        end
                    end
                    board_pkg::reg_phyctrl: phy_ctrl    <= acc.wdata[15:0];
                    board_pkg::reg_phydata: phy_data    <= acc.wdata[15:0];
                    board_pkg::reg_timeout: wdog_period <= acc.wdata[15:0];
                    default: ;  // read-only or unused slots
                endcase
            end

            // watchdog wins over any enable in the same cycle
            if (timeout) begin
                reg_disable <= '1;
            end
        end
    end

    //--------------------
    // state out
    //--------------------
    assign st.reg_disable = reg_disable;
    assign st.amp_disable = reg_disable | safety_amp_disable;  // either source kills axis
    assign st.relay_on    = relay_on;
    assign st.pwr_enable  = pwr_enable;
    assign st.dout        = dout;
    assign st.phy_ctrl    = phy_ctrl;
    assign st.phy_data    = phy_data;
    assign st.wdog_period = wdog_period;

endmodule

/* verilog/board_watchdog.sv */
// board watchdog
// prescaled tick counter, raises timeout when no page-0 write
// arrives within wdog_period ticks; any such write restarts it
module board_watchdog (
    input  logic        sysclk,
    input  logic        reset,    // sync, active low
    reg_access_if.kick  acc,
    ctrl_state_if.view  st,
    output logic        timeout   // sticky until next write
);

    logic [board_pkg::wdog_div_width-1:0] div_cnt;  // free-running prescaler
    logic                                 tick;
    logic [15:0]                          count;    // ticks since last write

    //--------------------
    // prescaler
    //--------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // one sysclk wide, once per wrap
    assign tick = &div_cnt;

    //--------------------
    // period counter
    //--------------------
    always_ff @(posedge sysclk) begin
        if (!reset || acc.wr) begin
            count   <= 16'd0;     // host activity restarts the window
            timeout <= 1'b0;
        end else if (tick && (st.wdog_period != 16'd0)) begin
            if (count < st.wdog_period) begin
                count <= count + 1'b1;
            end else begin
                timeout <= 1'b1;  // held until a write
            end
        end
        // zero period leaves count and flag idle
    end

endmodule

/* verilog/status_readback.sv */
// status readback
// result stage, packs the selected board register into a read word
// and registers it; holds on write cycles, zero otherwise
module status_readback (
    input  logic                           sysclk,
    input  logic                           reset,      // sync, active low
    reg_access_if.result                   acc,
    ctrl_state_if.view                     st,
    input  logic                           timeout,
    input  logic [3:0]                     board_id,   // rotary switch
    input  logic [board_pkg::num_axes-1:0] fault,      // 1 -> amp ok
    input  logic                           relay,      // relay feedback
    input  logic                           mv_good,    // motor voltage good
    input  logic                           v_fault,
    input  logic [board_pkg::num_axes-1:0] neg_limit,
    input  logic [board_pkg::num_axes-1:0] pos_limit,
    input  logic [board_pkg::num_axes-1:0] home,
    input  logic [15:0]                    temp_sense,
    input  logic [31:0]                    prom_status,
    input  logic [31:0]                    prom_result,
    input  logic [board_pkg::num_axes-1:0] safety_amp_disable,
    output logic [31:0]                    reg_rdata
);

    logic [31:0] rd_word;  // unregistered read mux

    //--------------------
    // read mux
    //--------------------
    always_comb begin
        case (acc.sel)
            board_pkg::reg_status: rd_word = {
                4'(board_pkg::num_axes), board_id,         // byte 3
                timeout, 3'd0,                             // byte 2 high
                mv_good, st.pwr_enable, ~relay, st.relay_on,
                4'd0, fault,                               // byte 1
                4'd0, ~st.reg_disable                      // byte 0, 1 -> enabled
            };
            board_pkg::reg_phyctrl:    rd_word = {16'd0, st.phy_ctrl};
            board_pkg::reg_phydata:    rd_word = {16'd0, st.phy_data};
            board_pkg::reg_timeout:    rd_word = {16'd0, st.wdog_period};
            board_pkg::reg_version:    rd_word = board_pkg::board_version;
            board_pkg::reg_tempsns:    rd_word = {16'd0, temp_sense};
            board_pkg::reg_digiout:    rd_word = {28'd0, st.dout};
            board_pkg::reg_fw_version: rd_word = board_pkg::fw_version;
            board_pkg::reg_promstat:   rd_word = prom_status;
            board_pkg::reg_promres:    rd_word = prom_result;
            board_pkg::reg_digin: rd_word = {
                15'd0, v_fault, st.dout, neg_limit, pos_limit, home
            };
            board_pkg::reg_safety:     rd_word = {28'd0, safety_amp_disable};
            board_pkg::reg_wdog:       rd_word = {28'd0, {4{timeout}}};
            board_pkg::reg_ampdis:     rd_word = {28'd0, st.amp_disable};
            default:                   rd_word = 32'd0;  // cur1, dac1 dropped
        endcase
    end

    //--------------------
    // result register
    //--------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            reg_rdata <= 32'd0;
        end else if (acc.rd) begin
            reg_rdata <= rd_word;
        end else if (!acc.wr) begin
            reg_rdata <= 32'd0;  // other pages read zero
        end
        // write cycles keep the last read word
    end

endmodule

/* verilog/board_regs_top.sv */
// board register file top
// host register access, control outputs and watchdog for the
// four-axis amplifier board
module board_regs_top (
    input  logic        sysclk,
    input  logic        reset,               // sync, active low

    // host side
    input  logic [7:0]  reg_addr,
    input  logic [31:0] reg_wdata,
    input  logic        wr_en,
    output logic [31:0] reg_rdata,

    // board inputs
    input  logic [3:0]  board_id,
    input  logic [3:0]  fault,
    input  logic        relay,
    input  logic        mv_good,
    input  logic        v_fault,
    input  logic [3:0]  neg_limit,
    input  logic [3:0]  pos_limit,
    input  logic [3:0]  home,
    input  logic [15:0] temp_sense,
    input  logic [31:0] prom_status,         // from external prom controller
    input  logic [31:0] prom_result,
    input  logic [3:0]  safety_amp_disable,

    // board outputs
    output logic [3:0]  amp_disable,
    output logic [3:0]  dout,
    output logic        pwr_enable,
    output logic        relay_on
);

    reg_access_if acc ();   // decoded host access
    ctrl_state_if st ();    // control register state
    logic timeout;          // watchdog flag

    reg_decode u_decode (
        .sysclk, .reset, .reg_addr, .reg_wdata, .wr_en,
        .acc (acc.decode)
    );

    board_ctrl_regs u_ctrl (
        .sysclk, .reset, .acc (acc.exec), .timeout, .safety_amp_disable,
        .st (st.owner)
    );

    board_watchdog u_wdog (
        .sysclk, .reset, .acc (acc.kick), .st (st.view), .timeout
    );

    status_readback u_readback (
        .sysclk, .reset, .acc (acc.result), .st (st.view), .timeout,
        .board_id, .fault, .relay, .mv_good, .v_fault, .neg_limit,
        .pos_limit, .home, .temp_sense, .prom_status, .prom_result,
        .safety_amp_disable, .reg_rdata
    );

    assign amp_disable = st.amp_disable;
    assign dout        = st.dout;
    assign pwr_enable  = st.pwr_enable;
    assign relay_on    = st.relay_on;

endmodule

/* verif/board_regs_assert.sv */
// board register file assertions
// reset values, safety disable coverage and watchdog forcing
module board_regs_assert (
    input logic       sysclk,
    input logic       reset,               // sync, active low
    input logic       relay_on,
    input logic       pwr_enable,
    input logic       timeout,             // watchdog flag inside the top
    input logic [3:0] amp_disable,
    input logic [3:0] safety_amp_disable
);
    timeunit 1ns;
    timeprecision 1ps;

    // relay and power off once reset has been seen
    reset_outputs_off: assert property (
        @(posedge sysclk) !reset |=> (!relay_on && !pwr_enable)
    ) else $error("relay_on or pwr_enable high after reset");

    // safety source always reaches the amplifiers
    safety_covered: assert property (
        @(posedge sysclk) disable iff (!reset)
        (amp_disable & safety_amp_disable) == safety_amp_disable
    ) else $error("amp_disable misses a safety disable bit");

    // timeout kills every axis one cycle later
    timeout_disables_all: assert property (
        @(posedge sysclk) disable iff (!reset)
        timeout |=> (amp_disable == 4'hF)
    ) else $error("amp_disable not all ones after watchdog timeout");

endmodule

bind board_regs_top board_regs_assert u_assert (
    .sysclk, .reset, .relay_on, .pwr_enable, .timeout,
    .amp_disable, .safety_amp_disable
);

/* verif/board_regs_tb.sv */
// board register file testbench
// table-driven host accesses checked against a reference model of the
// control state, then a watchdog timeout and recovery sequence
module board_regs_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic        sysclk;
    logic        reset;
    logic [7:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic        wr_en;
    logic [31:0] reg_rdata;
    logic [3:0]  board_id;
    logic [3:0]  fault;
    logic        relay;
    logic        mv_good;
    logic        v_fault;
    logic [3:0]  neg_limit;
    logic [3:0]  pos_limit;
    logic [3:0]  home;
    logic [15:0] temp_sense;
    logic [31:0] prom_status;
    logic [31:0] prom_result;
    logic [3:0]  safety_amp_disable;
    logic [3:0]  amp_disable;
    logic [3:0]  dout;
    logic        pwr_enable;
    logic        relay_on;

    //--------------------
    // stimulus table, one entry per column
    logic        tbl_wr[$];
    logic [7:0]  tbl_addr[$];
    logic [31:0] tbl_wdata[$];
    logic [31:0] tbl_exp[$];     // expected read word
    logic        tbl_chk[$];

    // reference model of the control state
    logic [3:0]  m_disable;      // 1 -> axis off
    logic        m_relay_on;
    logic        m_pwr;
    logic [3:0]  m_dout;

    integer      seed;
    int          errors;
    int          checks;
    int          cyc;
    int          seg_b;          // first row run with safety disable set
    logic [31:0] rnd;
    logic [31:0] rd;

    board_regs_top dut (
        .sysclk, .reset, .reg_addr, .reg_wdata, .wr_en, .reg_rdata,
        .board_id, .fault, .relay, .mv_good, .v_fault, .neg_limit,
        .pos_limit, .home, .temp_sense, .prom_status, .prom_result,
        .safety_amp_disable, .amp_disable, .dout, .pwr_enable, .relay_on
    );

    initial sysclk = 1'b0;
    always #5 sysclk = ~sysclk;  // 10 ns period

    //--------------------
    // expected words from the register map
    function automatic logic [31:0] status_exp(input logic [3:0] en, input logic rly_on,
                                               input logic pwr, input logic to);
        logic [31:0] w;
        w = 32'd0;
        w[3:0]   = en;           // 1 -> axis enabled
        w[11:8]  = fault;
        w[16]    = rly_on;
        w[17]    = ~relay;
        w[18]    = pwr;
        w[19]    = mv_good;
        w[23]    = to;
        w[27:24] = board_id;
        w[31:28] = 4'd4;         // axis count
        return w;
    endfunction

    function automatic logic [31:0] digin_exp(input logic [3:0] d);
        logic [31:0] w;
        w = 32'd0;
        w[3:0]   = home;
        w[7:4]   = pos_limit;
        w[11:8]  = neg_limit;
        w[15:12] = d;
        w[16]    = v_fault;
        return w;
    endfunction

    task automatic add_row(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp, input logic chk);
        tbl_wr.push_back(wr);
        tbl_addr.push_back(addr);
        tbl_wdata.push_back(wdata);
        tbl_exp.push_back(exp);
        tbl_chk.push_back(chk);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
        end
    endtask

    // masked pairs, page 0 only
    task automatic model_write(input logic [7:0] addr, input logic [31:0] wdata);
        if (addr[7:4] == 4'd0) begin
            if (addr[3:0] == 4'd0) begin
                for (int i = 0; i < 4; i++) begin
                    if (wdata[8 + i]) m_disable[i] = ~wdata[i];
                end
                if (wdata[17]) m_relay_on = wdata[16];
                if (wdata[19]) m_pwr = wdata[18];
            end else if (addr[3:0] == 4'd6) begin
                for (int i = 0; i < 4; i++) begin
                    if (wdata[8 + i]) m_dout[i] = wdata[i];
                end
            end
        end
    endtask

    task automatic check_outputs();
        check_value("amp_disable", 32'(amp_disable), 32'(m_disable | safety_amp_disable));
        check_value("dout", 32'(dout), 32'(m_dout));
        check_value("relay_on", 32'(relay_on), 32'(m_relay_on));
        check_value("pwr_enable", 32'(pwr_enable), 32'(m_pwr));
    endtask

    // one row per cycle, each checked two edges later
    task automatic run_rows(input int first, input int last);
        int n;
        int r;
        n = last - first + 1;
        for (int j = 0; j < n + 2; j++) begin
            @(negedge sysclk);
            if (j >= 2) begin
                r = first + j - 2;
                if (tbl_wr[r]) begin
                    model_write(tbl_addr[r], tbl_wdata[r]);
                    if (tbl_chk[r]) check_outputs();
                end else if (tbl_chk[r]) begin
                    check_value($sformatf("reg_rdata (row %0d)", r), reg_rdata, tbl_exp[r]);
                end
            end
            if (j < n) begin
                wr_en     = tbl_wr[first + j];
                reg_addr  = tbl_addr[first + j];
                reg_wdata = tbl_wdata[first + j];
            end else begin
                wr_en    = 1'b0;
                reg_addr = 8'h40;  // page 1, reads zero
            end
        end
    endtask

    task automatic do_write(input logic [7:0] addr, input logic [31:0] wdata);
        @(negedge sysclk);
        wr_en     = 1'b1;
        reg_addr  = addr;
        reg_wdata = wdata;
        @(negedge sysclk);
        wr_en    = 1'b0;
        reg_addr = 8'h40;
        @(negedge sysclk);  // state updated
        model_write(addr, wdata);
    endtask

    task automatic do_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge sysclk);
        wr_en    = 1'b0;
        reg_addr = addr;
        repeat (2) @(negedge sysclk);
        data = reg_rdata;
    endtask

    initial begin
        seed = 32'h5f4f12ba;
        errors = 0;
        checks = 0;
        reset = 1'b0;
        wr_en = 1'b0;
        reg_addr = 8'h40;
        reg_wdata = 32'd0;
        safety_amp_disable = 4'd0;
        rnd = $random(seed);        // board inputs, held for the whole run
        board_id  = rnd[3:0];
        fault     = rnd[7:4];
        relay     = rnd[8];
        mv_good   = rnd[9];
        v_fault   = rnd[10];
        neg_limit = rnd[15:12];
        pos_limit = rnd[19:16];
        home      = rnd[23:20];
        rnd = $random(seed);
        temp_sense  = rnd[15:0];
        prom_status = $random(seed);
        prom_result = $random(seed);
        m_disable  = 4'hF;          // all axes off out of reset
        m_relay_on = 1'b0;
        m_pwr      = 1'b0;
        m_dout     = 4'd0;

        // reset state
        add_row(0, 8'h00, 0, status_exp(4'b0000, 0, 0, 0), 1);
        add_row(0, 8'h03, 0, 32'h0000_FFFF, 1);
        add_row(0, 8'h04, 0, 32'h514C_4131, 1);
        add_row(0, 8'h07, 0, 32'h0000_0001, 1);
        add_row(0, 8'h0F, 0, 32'h0000_000F, 1);
        add_row(0, 8'h06, 0, 32'h0000_0000, 1);
        // masked status writes
        add_row(1, 8'h00, 32'h0000_0305, 0, 1);   // axis 0 on, axis 1 stays off
        add_row(1, 8'h00, 32'h000B_0C0C, 0, 1);   // axes 2,3 on, relay on
        add_row(1, 8'h00, 32'h0004_0000, 0, 1);   // no masks, nothing moves
        add_row(1, 8'h00, 32'h000C_0000, 0, 1);   // power on
        add_row(0, 8'h00, 0, status_exp(4'b1101, 1, 1, 0), 1);
        add_row(0, 8'h0F, 0, 32'h0000_0002, 1);
        // data registers
        add_row(1, 8'h06, 32'h0000_0F05, 0, 1);
        add_row(1, 8'h06, 32'h0000_0203, 0, 1);   // only dout bit 1 masked
        add_row(0, 8'h06, 0, 32'h0000_0007, 1);
        add_row(1, 8'h01, 32'hDEAD_1234, 0, 1);
        add_row(1, 8'h02, 32'hBEEF_ABCD, 0, 1);
        add_row(0, 8'h01, 0, 32'h0000_1234, 1);
        add_row(0, 8'h02, 0, 32'h0000_ABCD, 1);
        add_row(0, 8'h0A, 0, digin_exp(4'b0111), 1);
        add_row(0, 8'h05, 0, {16'd0, temp_sense}, 1);
        add_row(0, 8'h08, 0, prom_status, 1);
        add_row(0, 8'h09, 0, prom_result, 1);
        // other pages and dropped slots
        add_row(1, 8'h30, 32'h0008_0F00, 0, 1);   // would kill axes and power
        add_row(1, 8'h13, 32'h0000_5555, 0, 1);
        add_row(0, 8'h00, 0, status_exp(4'b1101, 1, 1, 0), 1);
        add_row(0, 8'h03, 0, 32'h0000_FFFF, 1);   // period untouched by page 1
        add_row(0, 8'h0C, 0, 32'h0000_0000, 1);
        add_row(0, 8'h0D, 0, 32'h0000_0000, 1);
        add_row(0, 8'h43, 0, 32'h0000_0000, 1);
        // safety disable 0101 from here
        seg_b = tbl_wr.size();
        add_row(0, 8'h0B, 0, 32'h0000_0005, 1);
        add_row(0, 8'h0F, 0, 32'h0000_0007, 1);
        add_row(0, 8'h00, 0, status_exp(4'b1101, 1, 1, 0), 1);

        repeat (4) @(negedge sysclk);
        reset = 1'b1;
        check_outputs();

        run_rows(0, seg_b - 1);
        @(negedge sysclk);
        safety_amp_disable = 4'b0101;
        run_rows(seg_b, tbl_wr.size() - 1);

        //--------------------
        // watchdog, period of 2 ticks
        do_write(8'h03, 32'h0000_0002);
        cyc = 0;
        while (amp_disable !== 4'hF && cyc < 2000) begin
            @(negedge sysclk);
            cyc++;
        end
        if (amp_disable !== 4'hF) begin
            errors++;
            $display("watchdog never disabled the axes within 2000 cycles");
        end
        m_disable = 4'hF;  // forced by the timeout
        do_read(8'h00, rd);
        check_value("reg_rdata (status, timeout)", rd, status_exp(4'b0000, 1, 1, 1));
        do_read(8'h0E, rd);
        check_value("reg_rdata (wdog)", rd, 32'h0000_000F);

        // unmasked write only kicks the watchdog
        do_write(8'h00, 32'h0000_0000);
        do_read(8'h0E, rd);
        check_value("reg_rdata (wdog cleared)", rd, 32'h0000_0000);
        do_read(8'h00, rd);
        check_value("reg_rdata (status, cleared)", rd, status_exp(4'b0000, 1, 1, 0));
        check_outputs();

        do_write(8'h00, 32'h0000_0F0F);  // re-enable every axis
        check_outputs();
        do_read(8'h0F, rd);
        check_value("reg_rdata (ampdis)", rd, 32'h0000_0005);

        $display("checks run %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
verilog/board_pkg.sv
verilog/board_ifs.sv
verilog/reg_decode.sv
verilog/board_ctrl_regs.sv
verilog/board_watchdog.sv
verilog/status_readback.sv
verilog/board_regs_top.sv
verif/board_regs_assert.sv
verif/board_regs_tb.sv

/* Makefile */
# Verilator build and run of the board register file testbench

TOP = board_regs_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "CHECKS FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
